// File: hw/cart_types_pkg.sv
package cart_types_pkg;

	// ******************************
	// Cartridge type ids (CRT header)
	// ******************************
	typedef logic [15:0] cart_id_t;

	localparam cart_id_t CART_GENERIC    = 16'd0;  // 8k, 16k and ultimax images
	localparam cart_id_t CART_OCEAN      = 16'd5;
	localparam cart_id_t CART_MAGIC_DESK = 16'd19;
	localparam cart_id_t CART_EASYFLASH  = 16'd32;
	localparam cart_id_t CART_XBANK      = 16'd33; // Same register set as EasyFlash

	// SDRAM bank number in 8 KB units
	typedef logic [6:0] bank_t;

	// Index into the bank table
	typedef logic [5:0] slot_t;

	// One CHIP packet as the loader hands it over
	typedef struct packed {
		logic [15:0] laddr;  // C64 load address
		logic [15:0] size;   // Packet length in bytes
		logic [15:0] num;    // Bank number from the packet
		logic [23:0] raddr;  // Where the packet sits in SDRAM
		logic        wr;     // One-cycle write pulse
	} crt_load_t;

	// ******************************
	// EasyFlash register byte
	// ******************************
	typedef struct packed {
		logic [1:0] spare;
		slot_t      slot;    // $DE00 bank select
	} ef_bank_reg_t;

	typedef struct packed {
		logic [4:0] spare;
		logic       jumper;  // Boot jumper, 0 keeps game low
		logic       exrom;
		logic       game;
	} ef_ctrl_reg_t;

	// Address bit 1 picks the view: 0 for $DE00, 1 for $DE02
	typedef union packed {
		ef_bank_reg_t bank;
		ef_ctrl_reg_t ctrl;
	} ef_reg_u;

	// Packets loading at or below this go to the low ROM table
	localparam logic [15:0] ROM_SPLIT_ADDR = 16'h8000;

	// Anything bigger also spills into the high ROM table
	localparam logic [15:0] BANK_SIZE_8K = 16'h2000;

	localparam int DEFAULT_SLOTS = 64;

endpackage

// File: hw/c64_bus_pkg.sv
package c64_bus_pkg;

	// ******************************
	// Expansion port as seen by the cart
	// ******************************
	typedef struct packed {
		logic [15:0] addr;      // CPU address
		logic  [7:0] wdata;     // CPU write data
		logic        write;     // Access is a write
		logic        mem_ce;    // SDRAM access requested
		logic        roml;      // $8000-$9FFF select
		logic        romh;      // $A000/$E000 select
		logic        umax_romh; // VIC fetch in ultimax mode
		logic        ioe;       // $DExx
		logic        iof;       // $DFxx
	} cpu_bus_t;

	// Registered mapper state, one set for all cart types
	typedef struct packed {
		cart_types_pkg::bank_t bank_lo;
		cart_types_pkg::bank_t bank_hi;
		logic                  use_table;  // Banks come from the table via slot
		cart_types_pkg::slot_t slot;
		logic                  exrom_ovr;
		logic                  game_ovr;
		logic                  ioe_ena;    // IOE reads go to SDRAM
		logic                  iof_ena;    // IOF reads go to SDRAM
		logic                  iof_wr_ena; // IOF writes go to SDRAM
		cart_types_pkg::bank_t ioe_bank;
		cart_types_pkg::bank_t iof_bank;
	} map_state_t;

	// Forced top bit of a translated ROM address
	localparam logic RAM_BANK_BIT = 1'b1;

endpackage

// File: hw/bank_table.sv
`timescale 1ns/1ps

module bank_table #(
	parameter int slot_count = cart_types_pkg::DEFAULT_SLOTS
) (
	input  logic                      clk32,
	input  logic                      reset,
	input  logic                      cart_loading,
	input  cart_types_pkg::crt_load_t load,
	input  cart_types_pkg::slot_t     slot,
	output cart_types_pkg::bank_t     lo_entry,
	output cart_types_pkg::bank_t     hi_entry
);

	localparam int idx_w = $clog2(slot_count);

	cart_types_pkg::bank_t lobanks [slot_count];
	cart_types_pkg::bank_t hibanks [slot_count];

	logic [idx_w-1:0] wr_idx;
	logic             wr_ok;
	logic             to_low;
	cart_types_pkg::bank_t raw_bank;

	assign wr_idx   = load.num[idx_w-1:0];
	assign wr_ok    = load.wr && (load.num < slot_count); // Out-of-range banks dropped
	assign to_low   = load.laddr <= cart_types_pkg::ROM_SPLIT_ADDR;
	assign raw_bank = load.raddr[19:13];

	// Table fill while the CRT file streams in
	always_ff @(posedge clk32) begin
		if (wr_ok) begin
			if (to_low) begin
				lobanks[wr_idx] <= raw_bank;
				if (load.size > cart_types_pkg::BANK_SIZE_8K)
					hibanks[wr_idx] <= raw_bank + 7'd1; // Upper half of a 16k packet
			end else begin
				hibanks[wr_idx] <= raw_bank;
			end
		end
	end

	// Live read of the selected slot
	always_comb begin
		lo_entry = '0;
		hi_entry = '0;
		if (int'(slot) < slot_count) begin
			lo_entry = lobanks[slot[idx_w-1:0]];
			hi_entry = hibanks[slot[idx_w-1:0]];
		end
	end

endmodule

// File: hw/mapper_regs.sv
`timescale 1ns/1ps

module mapper_regs (
	input  logic                     clk32,
	input  logic                     reset,
	input  c64_bus_pkg::cpu_bus_t    bus,
	input  cart_types_pkg::cart_id_t cart_id,
	input  logic [7:0]               cart_exrom,
	input  logic [7:0]               cart_game,
	output c64_bus_pkg::map_state_t  state
);

	// ******************************
	// Strobes
	// ******************************
	logic ioe_q;
	logic init_n;     // Low for the first edge after reset

	logic stb_ioe;
	logic ioe_wr;
	logic init;

	cart_types_pkg::ef_reg_u ef_reg;

	always_ff @(posedge clk32) begin
		if (!reset) begin
			ioe_q  <= 1'b0;
			init_n <= 1'b0;
		end else begin
			ioe_q  <= bus.ioe;
			init_n <= 1'b1;
		end
	end

	assign stb_ioe = bus.ioe && !ioe_q;
	assign ioe_wr  = stb_ioe && bus.write;
	assign init    = !init_n;

	assign ef_reg = bus.wdata; // Decoded per address bit 1

	// ******************************
	// Per-type register logic
	// ******************************
	always_ff @(posedge clk32) begin
		if (!reset) begin
			state.bank_lo    <= '0;
			state.bank_hi    <= '0;
			state.use_table  <= 1'b0;
			state.slot       <= '0;
			state.exrom_ovr  <= 1'b1;
			state.game_ovr   <= 1'b1;
			state.ioe_ena    <= 1'b0;
			state.iof_ena    <= 1'b0;
			state.iof_wr_ena <= 1'b0;
			state.ioe_bank   <= '0;
			state.iof_bank   <= '0;
		end else begin
			case (cart_id)
				// Mode lines straight from the CRT header
				cart_types_pkg::CART_GENERIC: begin
					state.exrom_ovr <= cart_exrom[0];
					state.game_ovr  <= cart_game[0];
					state.slot      <= '0;
					state.use_table <= 1'b1;
				end

				// 16k mode where $DE00 picks the bank for both halves
				cart_types_pkg::CART_OCEAN: begin
					state.exrom_ovr <= 1'b0;
					state.game_ovr  <= 1'b0;
					state.use_table <= 1'b0;
					if (ioe_wr) begin
						state.bank_lo <= {1'b0, bus.wdata[5:0]};
						state.bank_hi <= {1'b0, bus.wdata[5:0]};
					end
				end

				// 8k mode with bit 7 of $DE00 hiding the cart
				cart_types_pkg::CART_MAGIC_DESK: begin
					if (init) begin
						state.exrom_ovr <= 1'b0;
						state.game_ovr  <= 1'b1;
						state.bank_lo   <= '0;
						state.use_table <= 1'b0;
					end
					if (ioe_wr) begin
						state.bank_lo   <= {3'b000, bus.wdata[3:0]};
						state.exrom_ovr <= bus.wdata[7];
					end
				end

				cart_types_pkg::CART_EASYFLASH,
				cart_types_pkg::CART_XBANK: begin
					if (init) begin
						state.iof_bank   <= '0;
						state.iof_ena    <= 1'b1;     // 256 bytes of RAM at $DFxx
						state.iof_wr_ena <= 1'b1;
						state.exrom_ovr  <= cart_id == cart_types_pkg::CART_EASYFLASH;
						state.game_ovr   <= 1'b0;     // EasyFlash boots ultimax
						state.slot       <= '0;
						state.use_table  <= 1'b1;
					end
					if (ioe_wr) begin
						if (bus.addr[1]) begin // $DE02 control
							state.game_ovr  <= !ef_reg.ctrl.game && ef_reg.ctrl.jumper;
							state.exrom_ovr <= !ef_reg.ctrl.exrom;
						end else begin         // $DE00 bank
							state.slot      <= ef_reg.bank.slot;
							state.use_table <= 1'b1;
						end
					end
				end

				default: begin
					// Unsupported type keeps its reset state
				end
			endcase
		end
	end

endmodule

// File: hw/address_map.sv
`timescale 1ns/1ps

module address_map (
	input  c64_bus_pkg::cpu_bus_t   bus,
	input  c64_bus_pkg::map_state_t state,
	input  cart_types_pkg::bank_t   lo_entry,
	input  cart_types_pkg::bank_t   hi_entry,
	input  logic                    cart_attached,
	output logic [23:0]             sdram_address_out,
	output logic                    mem_ce_out,
	output logic                    exrom,
	output logic                    game
);

	cart_types_pkg::bank_t bank_lo;
	cart_types_pkg::bank_t bank_hi;
	logic                  ioe_ce;
	logic                  iof_ce;

	// Table entry or raw register bank
	assign bank_lo = state.use_table ? lo_entry : state.bank_lo;
	assign bank_hi = state.use_table ? hi_entry : state.bank_hi;

	// IO windows, only IOF has a write path
	assign ioe_ce = bus.ioe && !bus.write && state.ioe_ena;
	assign iof_ce = bus.iof && (bus.write ? state.iof_wr_ena : state.iof_ena);

	assign mem_ce_out = bus.mem_ce || ioe_ce || iof_ce;

	// ******************************
	// SDRAM address translation
	// ******************************
	always_comb begin
		sdram_address_out = {8'h00, bus.addr};
		if (cart_attached) begin
			if (bus.romh && !bus.write)
				sdram_address_out[23:13] = {c64_bus_pkg::RAM_BANK_BIT, 3'b000, bank_hi};
			if (bus.roml && !bus.write)
				sdram_address_out[23:13] = {c64_bus_pkg::RAM_BANK_BIT, 3'b000, bank_lo};
			if (ioe_ce)   // $DExx
				sdram_address_out[23:13] = {c64_bus_pkg::RAM_BANK_BIT, 3'b000, state.ioe_bank};
			if (iof_ce)   // $DFxx
				sdram_address_out[23:13] = {c64_bus_pkg::RAM_BANK_BIT, 3'b000, state.iof_bank};

			// VIC char fetch from the upper half of the high bank
			if (bus.umax_romh && !bus.write)
				sdram_address_out[23:12] = {c64_bus_pkg::RAM_BANK_BIT, 3'b000, bank_hi, 1'b1};
		end
	end

	// Lines released while no cart is in
	assign exrom = !cart_attached || state.exrom_ovr;
	assign game  = !cart_attached || state.game_ovr;

endmodule

// File: hw/cartridge.sv
`timescale 1ns/1ps

module cartridge #(
	parameter int slot_count = cart_types_pkg::DEFAULT_SLOTS
) (
	input  logic                      clk32,
	input  logic                      reset,
	input  c64_bus_pkg::cpu_bus_t     bus,
	input  cart_types_pkg::crt_load_t load,
	input  cart_types_pkg::cart_id_t  cart_id,
	input  logic [7:0]                cart_exrom,  // CRT header EXROM
	input  logic [7:0]                cart_game,   // CRT header GAME
	input  logic                      cart_attached,
	input  logic                      cart_loading,
	output logic [23:0]               sdram_address_out,
	output logic                      mem_ce_out,
	output logic                      exrom,
	output logic                      game
);

	c64_bus_pkg::map_state_t state;
	cart_types_pkg::bank_t   lo_entry;
	cart_types_pkg::bank_t   hi_entry;

	bank_table #(
		.slot_count (slot_count)
	) u_bank_table (
		.clk32        (clk32),
		.reset        (reset),
		.cart_loading (cart_loading),
		.load         (load),
		.slot         (state.slot),
		.lo_entry     (lo_entry),
		.hi_entry     (hi_entry)
	);

	mapper_regs u_mapper_regs (
		.clk32      (clk32),
		.reset      (reset),
		.bus        (bus),
		.cart_id    (cart_id),
		.cart_exrom (cart_exrom),
		.cart_game  (cart_game),
		.state      (state)
	);

	address_map u_address_map (
		.bus               (bus),
		.state             (state),
		.lo_entry          (lo_entry),
		.hi_entry          (hi_entry),
		.cart_attached     (cart_attached),
		.sdram_address_out (sdram_address_out),
		.mem_ce_out        (mem_ce_out),
		.exrom             (exrom),
		.game              (game)
	);

endmodule

// File: verification/cartridge_asserts.sv
`timescale 1ns/1ps

module cartridge_asserts (
	input logic                  clk32,
	input logic                  reset,
	input c64_bus_pkg::cpu_bus_t bus,
	input logic                  cart_attached,
	input logic [23:0]           sdram_address_out,
	input logic                  exrom,
	input logic                  game
);

	logic no_select;

	assign no_select = !(bus.roml || bus.romh || bus.umax_romh || bus.ioe || bus.iof);

	// Empty port leaves both mode lines pulled up
	lines_released: assert property (@(posedge clk32) disable iff (!reset)
		!cart_attached |-> exrom && game)
		else $error("exrom or game pulled low with no cartridge attached");

	// No ROM or IO select, so nothing to translate
	address_passthrough: assert property (@(posedge clk32) disable iff (!reset)
		no_select |-> sdram_address_out == {8'h00, bus.addr})
		else $error("address translated without any ROM or IO select");

endmodule

// File: verification/cartridge_tb.sv
`timescale 1ns/1ps

module cartridge_tb;

	localparam int step_count  = 34;
	localparam int col_count   = 16;
	localparam int cycle_limit = step_count * 4 + 50;

	logic                      clk32;
	logic                      reset;
	c64_bus_pkg::cpu_bus_t     bus;
	cart_types_pkg::crt_load_t load;
	cart_types_pkg::cart_id_t  cart_id;
	logic [7:0]                cart_exrom;
	logic [7:0]                cart_game;
	logic                      cart_attached;
	logic                      cart_loading;
	logic [23:0]               sdram_address_out;
	logic                      mem_ce_out;
	logic                      exrom;
	logic                      game;

	logic [23:0] steps [step_count * col_count];  // Flat copy of the input file
	logic [23:0] row [col_count];                 // Step being run
	int          cycles = 0;
	int          checks;
	int          errors;

	cartridge #(.slot_count(cart_types_pkg::DEFAULT_SLOTS)) DUT (.*);

	bind cartridge cartridge_asserts u_asserts (.*);

	always #10 clk32 = !clk32;

	// ******************************
	// Run limit
	// ******************************
	always @(posedge clk32) begin
		cycles <= cycles + 1;
		if (cycles >= cycle_limit) begin
			$display("Timeout after %0d cycles, the stimulus did not finish", cycles);
			$display("tests failed");
			$finish;
		end
	end

	// One CHIP packet into the bank table
	task automatic load_packet();
		@(posedge clk32);
		cart_loading <= 1'b1;
		load.laddr   <= row[8][15:0];
		load.size    <= row[9][15:0];
		load.num     <= row[10][15:0];
		load.raddr   <= row[11];
		load.wr      <= 1'b1;
		@(posedge clk32);
		load.wr <= 1'b0;
	endtask

	// New cart type, short reset so the mapper runs its init
	task automatic attach_cart();
		@(posedge clk32);
		reset         <= 1'b0;
		cart_loading  <= 1'b0;
		cart_id       <= row[1][15:0];
		cart_exrom    <= row[2][7:0];
		cart_game     <= row[3][7:0];
		cart_attached <= row[4][0];
		repeat (2) @(posedge clk32);
		reset <= 1'b1;
	endtask

	task automatic run_bus_step(input int s);
		logic [23:0] exp_addr;
		logic        exp_ce;
		logic        exp_exrom;
		logic        exp_game;
		int          bad;
		exp_addr  = row[12];
		exp_ce    = row[13][0];
		exp_exrom = row[14][0];
		exp_game  = row[15][0];
		bad       = 0;
		@(posedge clk32);
		bus.addr  <= row[5][15:0];
		bus.wdata <= row[6][7:0];
		{bus.write, bus.mem_ce, bus.roml, bus.romh, bus.umax_romh, bus.ioe, bus.iof}
			<= row[7][6:0];
		@(posedge clk32);  // Mapper takes the strobe here
		@(negedge clk32);
		assert (sdram_address_out == exp_addr) else begin
			$display("FAILED %0t: step %0d sdram address %h, expected %h",
				$time, s, sdram_address_out, exp_addr);
			bad++;
		end
		assert (mem_ce_out == exp_ce) else begin
			$display("FAILED %0t: step %0d mem_ce_out %b, expected %b",
				$time, s, mem_ce_out, exp_ce);
			bad++;
		end
		assert ({exrom, game} == {exp_exrom, exp_game}) else begin
			$display("FAILED %0t: step %0d exrom/game %b%b, expected %b%b",
				$time, s, exrom, game, exp_exrom, exp_game);
			bad++;
		end
		checks++;
		if (bad != 0)
			errors++;
		$display("step %0d %s", s, (bad == 0) ? "ok" : "mismatch");
		@(posedge clk32);
		bus <= '0;  // Idle so the next IO access gives a fresh edge
	endtask

	// ******************************
	// Main sequence
	// ******************************
	initial begin
		clk32         = 1'b0;
		reset         = 1'b0;
		bus           = '0;
		load          = '0;
		cart_id       = '0;
		cart_exrom    = '0;
		cart_game     = '0;
		cart_attached = 1'b0;
		cart_loading  = 1'b0;
		checks        = 0;
		errors        = 0;
		$readmemh("verification/cartridge_input.txt", steps);
		repeat (10) @(posedge clk32);
		reset <= 1'b1;
		for (int s = 1; s <= step_count; s++) begin
			for (int c = 0; c < col_count; c++)
				row[c] = steps[(s - 1) * col_count + c];
			case (row[0])
				24'h1:   load_packet();
				24'h2:   attach_cart();
				default: run_bus_step(s);
			endcase
		end
		@(posedge clk32);
		$display("%0d steps checked, %0d with errors", checks, errors);
		if (errors == 0)
			$display("all tests passed");
		else
			$display("tests failed");
		$finish;
	end

endmodule

// File: verification/cartridge_input.txt
// kind (0 bus, 1 load, 2 cart)  id exrom game attached  addr wdata ctl  laddr size num raddr
// exp_addr exp_ce exp_exrom exp_game; ctl bits: write mem_ce roml romh umax_romh ioe iof
2 0000 00 00 0 0000 00 00 0000 0000 0000 000000 000000 0 0 0
0 0000 00 00 0 8123 00 30 0000 0000 0000 000000 008123 1 1 1
0 0000 00 00 0 1234 00 20 0000 0000 0000 000000 001234 1 1 1
2 0000 00 00 1 0000 00 00 0000 0000 0000 000000 000000 0 0 0
1 0000 00 00 0 0000 00 00 8000 4000 0000 040000 000000 0 0 0
0 0000 00 00 0 8123 00 30 0000 0000 0000 000000 840123 1 0 0
0 0000 00 00 0 A456 00 28 0000 0000 0000 000000 842456 1 0 0
2 0000 00 01 1 0000 00 00 0000 0000 0000 000000 000000 0 0 0
0 0000 00 00 0 1234 00 20 0000 0000 0000 000000 001234 1 0 1
2 0005 00 00 1 0000 00 00 0000 0000 0000 000000 000000 0 0 0
0 0000 00 00 0 DE00 05 42 0000 0000 0000 000000 00DE00 0 0 0
0 0000 00 00 0 8123 00 30 0000 0000 0000 000000 80A123 1 0 0
0 0000 00 00 0 DE00 EA 42 0000 0000 0000 000000 00DE00 0 0 0
0 0000 00 00 0 BFFF 00 28 0000 0000 0000 000000 855FFF 1 0 0
2 0013 00 00 1 0000 00 00 0000 0000 0000 000000 000000 0 0 0
0 0000 00 00 0 8010 00 30 0000 0000 0000 000000 800010 1 0 1
0 0000 00 00 0 DE00 03 42 0000 0000 0000 000000 00DE00 0 0 1
0 0000 00 00 0 8010 00 30 0000 0000 0000 000000 806010 1 0 1
0 0000 00 00 0 DE00 8F 42 0000 0000 0000 000000 00DE00 0 1 1
0 0000 00 00 0 8010 00 30 0000 0000 0000 000000 81E010 1 1 1
1 0000 00 00 0 0000 00 00 8000 2000 0001 0C2000 000000 0 0 0
1 0000 00 00 0 0000 00 00 A000 2000 0001 0C4000 000000 0 0 0
2 0020 00 00 1 0000 00 00 0000 0000 0000 000000 000000 0 0 0
0 0000 00 00 0 1000 00 20 0000 0000 0000 000000 001000 1 1 0
2 0021 00 00 1 0000 00 00 0000 0000 0000 000000 000000 0 0 0
0 0000 00 00 0 1000 00 20 0000 0000 0000 000000 001000 1 0 0
0 0000 00 00 0 DE00 01 42 0000 0000 0000 000000 00DE00 0 0 0
0 0000 00 00 0 8123 00 30 0000 0000 0000 000000 8C2123 1 0 0
0 0000 00 00 0 A456 00 28 0000 0000 0000 000000 8C4456 1 0 0
0 0000 00 00 0 DE00 00 02 0000 0000 0000 000000 00DE00 0 0 0
0 0000 00 00 0 DE02 06 42 0000 0000 0000 000000 00DE02 0 0 1
0 0000 00 00 0 DE02 04 42 0000 0000 0000 000000 00DE02 0 1 1
0 0000 00 00 0 DF10 55 41 0000 0000 0000 000000 801F10 1 1 1
0 0000 00 00 0 DF10 00 01 0000 0000 0000 000000 801F10 1 1 1

// File: all.f
hw/cart_types_pkg.sv
hw/c64_bus_pkg.sv
hw/bank_table.sv
hw/mapper_regs.sv
hw/address_map.sv
hw/cartridge.sv
verification/cartridge_asserts.sv
verification/cartridge_tb.sv

// File: Bender.yml
package:
  name: cartridge

sources:
  - hw/cart_types_pkg.sv
  - hw/c64_bus_pkg.sv
  - hw/bank_table.sv
  - hw/mapper_regs.sv
  - hw/address_map.sv
  - hw/cartridge.sv
  - target: test
    files:
      - verification/cartridge_asserts.sv
      - verification/cartridge_tb.sv
